/* src/xdata_pkg.sv */
package xdata_pkg;

   // data path sizes
   localparam int DATA_W      = 32;
   localparam int N_MEM       = 2;
   localparam int N_MEM_W     = 1;
   localparam int MEM_ADDR_W  = 6;
   localparam int MEM_DEPTH   = 2 ** MEM_ADDR_W;
   localparam int HOST_ADDR_W = 1 + N_MEM_W + MEM_ADDR_W;
   localparam int N_ALU       = 2;

   // data bus sources, codes 6 and 7 read as zero
   localparam int N_SRC     = 6;
   localparam int SRC_W     = 3;
   localparam int SRC_MEM0A = 0;
   localparam int SRC_MEM0B = 1;
   localparam int SRC_MEM1A = 2;
   localparam int SRC_MEM1B = 3;
   localparam int SRC_ALU0  = 4;
   localparam int SRC_ALU1  = 5;

   // memory port config fields, low end first
   localparam int MEMP_CONF_BITS = 31;
   localparam int MP_ITER_W      = 7;
   localparam int MP_DELAY_W     = 3;
   localparam int MP_START_LSB   = 0;
   localparam int MP_STRIDE_LSB  = MP_START_LSB + MEM_ADDR_W;
   localparam int MP_ITER_LSB    = MP_STRIDE_LSB + MEM_ADDR_W;
   localparam int MP_DELAY_LSB   = MP_ITER_LSB + MP_ITER_W;
   localparam int MP_WE_BIT      = MP_DELAY_LSB + MP_DELAY_W;
   localparam int MP_WSRC_LSB    = MP_WE_BIT + 1;

   // alu config fields
   localparam int ALU_OP_W      = 3;
   localparam int ALU_OP_LSB    = 0;
   localparam int ALU_SRCA_LSB  = ALU_OP_LSB + ALU_OP_W;
   localparam int ALU_SRCB_LSB  = ALU_SRCA_LSB + SRC_W;
   localparam int ALU_CONF_BITS = ALU_OP_W + 2 * SRC_W;

   // full config vector: four memory ports, then the alus
   localparam int CONF_BITS      = 4 * MEMP_CONF_BITS + 2 * ALU_CONF_BITS;
   localparam int CONF_MEM0A_OFF = 0;
   localparam int CONF_MEM0B_OFF = CONF_MEM0A_OFF + MEMP_CONF_BITS;
   localparam int CONF_MEM1A_OFF = CONF_MEM0B_OFF + MEMP_CONF_BITS;
   localparam int CONF_MEM1B_OFF = CONF_MEM1A_OFF + MEMP_CONF_BITS;
   localparam int CONF_ALU0_OFF  = CONF_MEM1B_OFF + MEMP_CONF_BITS;
   localparam int CONF_ALU1_OFF  = CONF_ALU0_OFF + ALU_CONF_BITS;

   // control region register map
   localparam int CTRL_REG_IDX   = 0;
   localparam int CONF_MEM0A_IDX = 1;
   localparam int CONF_MEM0B_IDX = 2;
   localparam int CONF_MEM1A_IDX = 3;
   localparam int CONF_MEM1B_IDX = 4;
   localparam int CONF_ALU0_IDX  = 5;
   localparam int CONF_ALU1_IDX  = 6;

   typedef enum logic [ALU_OP_W-1:0] {
      ADD, SUB, AND, OR, XOR, MAX, MIN, PASSA
   } alu_op_e;

   typedef enum logic [1:0] {
      IDLE, WAIT, RUN, DONE
   } addr_gen_state_e;

   // pick one word off the data bus by source code
   function automatic logic [DATA_W-1:0] bus_select(
      input logic [N_SRC*DATA_W-1:0] bus,
      input logic [SRC_W-1:0]        src
   );
      logic [DATA_W-1:0] word;
      word = '0;
      if (src < N_SRC)
         word = bus[src*DATA_W +: DATA_W];
      return word;
   endfunction

endpackage

/* src/xaddr_gen.sv */
`timescale 1ns/1ps

module xaddr_gen
   import xdata_pkg::*;
(
   input  logic                  rst,
   input  logic                  clk,
   input  logic                  start_pulse,
   input  logic [MEM_ADDR_W-1:0] conf_start,
   input  logic [MEM_ADDR_W-1:0] conf_stride,
   input  logic [MP_ITER_W-1:0]  conf_iter,
   input  logic [MP_DELAY_W-1:0] conf_delay,
   output logic [MEM_ADDR_W-1:0] addr_out,
   output logic                  en,
   output logic                  done
);

   addr_gen_state_e       state;
   logic [MP_DELAY_W-1:0] delay_cnt;
   logic [MP_ITER_W-1:0]  iter_cnt;

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         state     <= DONE;
         delay_cnt <= '0;
         iter_cnt  <= '0;
         addr_out  <= '0;
      end else if (start_pulse) begin
         // a new run reloads from any state
         delay_cnt <= conf_delay;
         iter_cnt  <= conf_iter;
         addr_out  <= conf_start;
         if (conf_iter == '0)
            state <= DONE;
         else if (conf_delay == '0)
            state <= RUN;
         else
            state <= WAIT;
      end else begin
         case (state)
            WAIT: begin
               delay_cnt <= delay_cnt - 1'b1;
               if (delay_cnt == MP_DELAY_W'(1))
                  state <= RUN;
            end
            RUN: begin
               // stride is two's complement, wraps mod 64
               addr_out <= addr_out + conf_stride;
               iter_cnt <= iter_cnt - 1'b1;
               if (iter_cnt == MP_ITER_W'(1))
                  state <= DONE;
            end
            // never entered from a run, settle in done
            IDLE: state <= DONE;
            DONE: ;
         endcase
      end
   end

   assign en = (state == RUN);

   // low already in the start cycle so status drops right after the strobe
   assign done = (state == DONE) & ~start_pulse;

endmodule

/* src/xmem_unit.sv */
`timescale 1ns/1ps

module xmem_unit
   import xdata_pkg::*;
(
   input  logic                        rst,
   input  logic                        clk,
   input  logic                        run,
   input  logic                        host_valid,
   input  logic                        host_we,
   input  logic [MEM_ADDR_W-1:0]       host_addr,
   input  logic [DATA_W-1:0]           host_data,
   input  logic [N_SRC*DATA_W-1:0]     bus,
   input  logic [2*MEMP_CONF_BITS-1:0] conf,
   output logic [DATA_W-1:0]           out_a,
   output logic [DATA_W-1:0]           out_b,
   output logic                        done_a,
   output logic                        done_b
);

   logic [DATA_W-1:0]     mem [MEM_DEPTH];
   logic [MEM_ADDR_W-1:0] gen_addr [2];
   logic [DATA_W-1:0]     port_wdata [2];
   logic [1:0]            gen_en;
   logic [1:0]            gen_done;
   logic [1:0]            port_we;
   logic [MEM_ADDR_W-1:0] addr_a;
   logic                  we_a;
   logic [DATA_W-1:0]     wdata_a;

   // port A config in the low half, port B in the high half
   genvar p;
   generate
      for (p = 0; p < 2; p++) begin : g_port
         logic [MEMP_CONF_BITS-1:0] pconf;

         assign pconf = conf[p*MEMP_CONF_BITS +: MEMP_CONF_BITS];

         xaddr_gen u_gen (
            .rst         (rst),
            .clk         (clk),
            .start_pulse (run),
            .conf_start  (pconf[MP_START_LSB +: MEM_ADDR_W]),
            .conf_stride (pconf[MP_STRIDE_LSB +: MEM_ADDR_W]),
            .conf_iter   (pconf[MP_ITER_LSB +: MP_ITER_W]),
            .conf_delay  (pconf[MP_DELAY_LSB +: MP_DELAY_W]),
            .addr_out    (gen_addr[p]),
            .en          (gen_en[p]),
            .done        (gen_done[p])
         );

         assign port_we[p]    = gen_en[p] & pconf[MP_WE_BIT];
         assign port_wdata[p] = bus_select(bus, pconf[MP_WSRC_LSB +: SRC_W]);
      end
   endgenerate

   // host takes over port A
   always_comb begin
      if (host_valid) begin
         addr_a  = host_addr;
         we_a    = host_we;
         wdata_a = host_data;
      end else begin
         addr_a  = gen_addr[0];
         we_a    = port_we[0];
         wdata_a = port_wdata[0];
      end
   end

   always_ff @(posedge rst) begin
      if (we_a)
         mem[addr_a] <= wdata_a;
      if (port_we[1])
         mem[gen_addr[1]] <= port_wdata[1];
   end

   // registered reads, these words drive the data bus
   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         out_a <= '0;
         out_b <= '0;
      end else begin
         out_a <= mem[addr_a];
         out_b <= mem[gen_addr[1]];
      end
   end

   assign done_a = gen_done[0];
   assign done_b = gen_done[1];

endmodule

/* src/xalu_unit.sv */
`timescale 1ns/1ps

module xalu_unit
   import xdata_pkg::*;
(
   input  logic                     rst,
   input  logic                     clk,
   input  logic [N_SRC*DATA_W-1:0]  bus,
   input  logic [ALU_CONF_BITS-1:0] conf,
   output logic [DATA_W-1:0]        result
);

   alu_op_e           op;
   logic [DATA_W-1:0] op_a;
   logic [DATA_W-1:0] op_b;
   logic [DATA_W-1:0] res_next;

   assign op   = alu_op_e'(conf[ALU_OP_LSB +: ALU_OP_W]);
   assign op_a = bus_select(bus, conf[ALU_SRCA_LSB +: SRC_W]);
   assign op_b = bus_select(bus, conf[ALU_SRCB_LSB +: SRC_W]);

   always_comb begin
      case (op)
         ADD:     res_next = op_a + op_b;
         SUB:     res_next = op_a - op_b;
         AND:     res_next = op_a & op_b;
         OR:      res_next = op_a | op_b;
         XOR:     res_next = op_a ^ op_b;
         // max and min compare as signed words
         MAX:     res_next = ($signed(op_a) > $signed(op_b)) ? op_a : op_b;
         MIN:     res_next = ($signed(op_a) < $signed(op_b)) ? op_a : op_b;
         PASSA:   res_next = op_a;
         default: res_next = '0;
      endcase
   end

   // one cycle from operands on the bus to result on the bus
   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         result <= '0;
      else
         result <= res_next;
   end

endmodule

/* src/xconf_regs.sv */
`timescale 1ns/1ps

module xconf_regs
   import xdata_pkg::*;
(
   input  logic                   rst,
   input  logic                   clk,
   input  logic                   valid,
   input  logic                   we,
   input  logic [HOST_ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0]      rdata,
   output logic [CONF_BITS-1:0]   conf
);

   logic                      conf_wr;
   logic [HOST_ADDR_W-2:0]    reg_idx;
   logic [MEMP_CONF_BITS-1:0] mp_word;
   logic [ALU_CONF_BITS-1:0]  alu_word;

   // control region writes only
   assign conf_wr  = valid & we & addr[HOST_ADDR_W-1];
   assign reg_idx  = addr[HOST_ADDR_W-2:0];
   assign mp_word  = rdata[MEMP_CONF_BITS-1:0];
   assign alu_word = rdata[ALU_CONF_BITS-1:0];

   always_ff @(posedge rst or posedge clk) begin
      if (clk) begin
         conf <= '0;
      end else if (conf_wr) begin
         case (reg_idx)
            CONF_MEM0A_IDX: conf[CONF_MEM0A_OFF +: MEMP_CONF_BITS] <= mp_word;
            CONF_MEM0B_IDX: conf[CONF_MEM0B_OFF +: MEMP_CONF_BITS] <= mp_word;
            CONF_MEM1A_IDX: conf[CONF_MEM1A_OFF +: MEMP_CONF_BITS] <= mp_word;
            CONF_MEM1B_IDX: conf[CONF_MEM1B_OFF +: MEMP_CONF_BITS] <= mp_word;
            CONF_ALU0_IDX:  conf[CONF_ALU0_OFF +: ALU_CONF_BITS] <= alu_word;
            CONF_ALU1_IDX:  conf[CONF_ALU1_OFF +: ALU_CONF_BITS] <= alu_word;
            // index 0 is the run control, handled in the engine
            default: ;
         endcase
      end
   end

endmodule

/* src/xdata_eng.sv */
`timescale 1ns/1ps

module xdata_eng
   import xdata_pkg::*;
(
   input  logic                   rst,
   input  logic                   clk,
   input  logic                   valid,
   input  logic                   we,
   input  logic [HOST_ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0]      rdata,
   output logic [DATA_W-1:0]      wdata,
   input  logic [CONF_BITS-1:0]   config_bus
);

   // one word per source, source code i at word i
   wire  [N_SRC*DATA_W-1:0] data_bus;
   wire  [2*N_MEM-1:0]      mem_done;

   logic [HOST_ADDR_W-2:0]  reg_idx;
   logic [N_MEM_W-1:0]      mem_sel;
   logic [N_MEM_W-1:0]      addr_reg;
   logic                    ctrl_valid;
   logic                    status_sel;
   logic                    all_done;
   logic [N_MEM-1:0]        mem_valid;
   logic                    run;
   logic                    run_reg;
   logic [CONF_BITS-1:0]    conf_shadow;

   // address decoder
   assign reg_idx    = addr[HOST_ADDR_W-2:0];
   assign mem_sel    = addr[HOST_ADDR_W-2 -: N_MEM_W];
   assign ctrl_valid = valid & addr[HOST_ADDR_W-1];
   assign status_sel = ctrl_valid & (reg_idx == CTRL_REG_IDX);
   assign all_done   = &mem_done;

   // memory access only between runs
   always_comb begin
      mem_valid = '0;
      for (int j = 0; j < N_MEM; j++) begin
         if (mem_sel == N_MEM_W'(j))
            mem_valid[j] = valid & ~addr[HOST_ADDR_W-1] & all_done;
      end
   end

   // memory index of the previous access, for the read-back
   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         addr_reg <= '0;
      else
         addr_reg <= mem_sel;
   end

   always_comb begin
      if (status_sel)
         wdata = {{(DATA_W-1){1'b0}}, all_done};
      else if (ctrl_valid)
         wdata = '0;
      else
         wdata = data_bus[(SRC_MEM0A + 2*addr_reg)*DATA_W +: DATA_W];
   end

   // run strobe and its registered pulse
   assign run = status_sel & we & rdata[0];

   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         run_reg <= 1'b0;
      else
         run_reg <= run;
   end

   // units only ever see the shadow copy
   always_ff @(posedge rst or posedge clk) begin
      if (clk)
         conf_shadow <= '0;
      else if (run)
         conf_shadow <= config_bus;
   end

   genvar i;

   generate
      for (i = 0; i < N_MEM; i++) begin : g_mem
         xmem_unit u_mem (
            .rst        (rst),
            .clk        (clk),
            .run        (run_reg),
            .host_valid (mem_valid[i]),
            .host_we    (we),
            .host_addr  (addr[MEM_ADDR_W-1:0]),
            .host_data  (rdata),
            .bus        (data_bus),
            .conf       (conf_shadow[CONF_MEM0A_OFF + 2*i*MEMP_CONF_BITS +: 2*MEMP_CONF_BITS]),
            .out_a      (data_bus[(SRC_MEM0A + 2*i)*DATA_W +: DATA_W]),
            .out_b      (data_bus[(SRC_MEM0B + 2*i)*DATA_W +: DATA_W]),
            .done_a     (mem_done[2*i]),
            .done_b     (mem_done[2*i+1])
         );
      end
   endgenerate

   generate
      for (i = 0; i < N_ALU; i++) begin : g_alu
         xalu_unit u_alu (
            .rst    (rst),
            .clk    (clk),
            .bus    (data_bus),
            .conf   (conf_shadow[CONF_ALU0_OFF + i*ALU_CONF_BITS +: ALU_CONF_BITS]),
            .result (data_bus[(SRC_ALU0 + i)*DATA_W +: DATA_W])
         );
      end
   endgenerate

endmodule

/* src/xversat_top.sv */
`timescale 1ns/1ps

module xversat_top
   import xdata_pkg::*;
(
   input  logic                   rst,
   input  logic                   clk,
   input  logic                   valid,
   input  logic                   we,
   input  logic [HOST_ADDR_W-1:0] addr,
   input  logic [DATA_W-1:0]      rdata,
   output logic [DATA_W-1:0]      wdata
);

   logic [CONF_BITS-1:0] conf;

   // host-side config registers
   xconf_regs u_conf_regs (
      .rst   (rst),
      .clk   (clk),
      .valid (valid),
      .we    (we),
      .addr  (addr),
      .rdata (rdata),
      .conf  (conf)
   );

   xdata_eng u_data_eng (
      .rst        (rst),
      .clk        (clk),
      .valid      (valid),
      .we         (we),
      .addr       (addr),
      .rdata      (rdata),
      .wdata      (wdata),
      .config_bus (conf)
   );

endmodule

/* tests/tb_xversat_tasks.svh */
// control region register address
function automatic logic [HOST_ADDR_W-1:0] ctrl_addr(input int idx);
   return {1'b1, idx[HOST_ADDR_W-2:0]};
endfunction

function automatic logic [HOST_ADDR_W-1:0] mem_addr(input int m, input int w);
   return {1'b0, m[N_MEM_W-1:0], w[MEM_ADDR_W-1:0]};
endfunction

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
   return lcg_state;
endfunction

// reference alu result for one opcode
function automatic logic [DATA_W-1:0] alu_model(input alu_op_e op,
                                                input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
   logic [DATA_W-1:0] a_ofs;
   logic [DATA_W-1:0] b_ofs;
   // sign bit flipped so an unsigned compare orders signed words
   a_ofs = a ^ {1'b1, {(DATA_W-1){1'b0}}};
   b_ofs = b ^ {1'b1, {(DATA_W-1){1'b0}}};
   case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      MAX:     return (a_ofs > b_ofs) ? a : b;
      MIN:     return (a_ofs < b_ofs) ? a : b;
      default: return a;
   endcase
endfunction

// inputs change 2 ns after the rising edge
task automatic next_cycle();
   @(posedge rst);
   #2;
endtask

task automatic check_word(input string name, input logic [DATA_W-1:0] exp,
                          input logic [DATA_W-1:0] got);
   assert (got === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, got);
      errors++;
   end
endtask

task automatic finish_test(input string name, input int errors_before);
   tests_run++;
   if (errors == errors_before) begin
      $display("%-18s ok", name);
   end else begin
      tests_failed++;
      $display("%-18s %0d failed checks", name, errors - errors_before);
   end
endtask

task automatic write_reg(input int idx, input logic [DATA_W-1:0] data);
   next_cycle();
   valid = 1'b1;
   we    = 1'b1;
   addr  = ctrl_addr(idx);
   rdata = data;
endtask

task automatic write_mem(input int m, input int w, input logic [DATA_W-1:0] data);
   next_cycle();
   valid = 1'b1;
   we    = 1'b1;
   addr  = mem_addr(m, w);
   rdata = data;
endtask

// memory data shows on wdata one cycle after the read
task automatic read_mem(input int m, input int w, output logic [DATA_W-1:0] data);
   next_cycle();
   valid = 1'b1;
   we    = 1'b0;
   addr  = mem_addr(m, w);
   next_cycle();
   valid = 1'b0;
   @(negedge rst);
   data = wdata;
endtask

task automatic read_status(output logic [DATA_W-1:0] status);
   next_cycle();
   valid = 1'b1;
   we    = 1'b0;
   addr  = ctrl_addr(CTRL_REG_IDX);
   @(negedge rst);
   status = wdata;
endtask

task automatic set_port(input int idx, input int start, input int stride, input int iter,
                        input int delay, input bit wen, input int wsrc);
   logic [DATA_W-1:0] word;
   word = '0;
   word[MP_START_LSB +: MEM_ADDR_W]  = start[MEM_ADDR_W-1:0];
   word[MP_STRIDE_LSB +: MEM_ADDR_W] = stride[MEM_ADDR_W-1:0];
   word[MP_ITER_LSB +: MP_ITER_W]    = iter[MP_ITER_W-1:0];
   word[MP_DELAY_LSB +: MP_DELAY_W]  = delay[MP_DELAY_W-1:0];
   word[MP_WE_BIT]                   = wen;
   word[MP_WSRC_LSB +: SRC_W]        = wsrc[SRC_W-1:0];
   write_reg(idx, word);
endtask

task automatic set_alu(input int idx, input alu_op_e op, input int src_a, input int src_b);
   logic [DATA_W-1:0] word;
   word = '0;
   word[ALU_OP_LSB +: ALU_OP_W]  = op;
   word[ALU_SRCA_LSB +: SRC_W]   = src_a[SRC_W-1:0];
   word[ALU_SRCB_LSB +: SRC_W]   = src_b[SRC_W-1:0];
   write_reg(idx, word);
endtask

task automatic start_run();
   write_reg(CTRL_REG_IDX, 32'd1);
endtask

// poll status until done from the cycle after the strobe
task automatic wait_done(input string name);
   logic [DATA_W-1:0] status;
   int                polls;
   status = '0;
   polls  = 0;
   while (status[0] !== 1'b1 && polls < POLL_LIMIT) begin
      read_status(status);
      polls++;
   end
   assert (status[0] === 1'b1) else begin
      $display("%s: engine never finished after %0d status polls", name, polls);
      errors++;
   end
endtask

// a goes to mem0 0..n-1 and b to mem0 32 onward
task automatic load_operands(input int n);
   for (int k = 0; k < n; k++) begin
      vec_a[k] = lcg_next();
      vec_b[k] = lcg_next();
      write_mem(0, k, vec_a[k]);
      write_mem(0, 32 + k, vec_b[k]);
   end
endtask

// mem0A op mem0B through alu0 into mem1 0..15
task automatic set_binary_op(input alu_op_e op);
   set_port(CONF_MEM0A_IDX, 0, 1, 16, 0, 1'b0, 0);
   set_port(CONF_MEM0B_IDX, 32, 1, 16, 0, 1'b0, 0);
   set_port(CONF_MEM1A_IDX, 0, 0, 0, 0, 1'b0, 0);
   set_port(CONF_MEM1B_IDX, 0, 1, 16, 2, 1'b1, SRC_ALU0);
   set_alu(CONF_ALU0_IDX, op, SRC_MEM0A, SRC_MEM0B);
   set_alu(CONF_ALU1_IDX, PASSA, SRC_MEM0A, SRC_MEM0A);
endtask

task automatic check_binary_op(input string name, input alu_op_e op);
   logic [DATA_W-1:0] got;
   for (int k = 0; k < 16; k++) begin
      read_mem(1, k, got);
      check_word($sformatf("%s op %0d word %0d", name, op, k),
                 alu_model(op, vec_a[k], vec_b[k]), got);
   end
endtask

task automatic memory_readback();
   int                err0;
   logic [DATA_W-1:0] data [N_MEM][MEM_DEPTH];
   logic [DATA_W-1:0] got;
   err0 = errors;
   read_status(got);
   check_word("memory_readback status", 32'd1, got);
   // fill both memories before any read so each word must come from its own address
   for (int m = 0; m < N_MEM; m++) begin
      for (int w = 0; w < MEM_DEPTH; w++) begin
         data[m][w] = lcg_next();
         write_mem(m, w, data[m][w]);
      end
   end
   for (int m = 0; m < N_MEM; m++) begin
      for (int w = 0; w < MEM_DEPTH; w++) begin
         read_mem(m, w, got);
         check_word($sformatf("memory_readback mem%0d word %0d", m, w), data[m][w], got);
      end
   end
   finish_test("memory_readback", err0);
endtask

task automatic vector_add();
   int err0;
   err0 = errors;
   load_operands(16);
   set_binary_op(ADD);
   start_run();
   wait_done("vector_add");
   check_binary_op("vector_add", ADD);
   finish_test("vector_add", err0);
endtask

task automatic alu_opcodes();
   int      err0;
   alu_op_e op;
   err0 = errors;
   load_operands(16);
   for (int k = 0; k < 8; k++) begin
      op = alu_op_e'(k);
      set_binary_op(op);
      start_run();
      wait_done("alu_opcodes");
      check_binary_op("alu_opcodes", op);
   end
   finish_test("alu_opcodes", err0);
endtask

// read mem0 from 63 downward and write mem1 upward
task automatic reverse_copy();
   int                err0;
   logic [DATA_W-1:0] got;
   err0 = errors;
   for (int k = 0; k < MEM_DEPTH; k++) begin
      vec_a[k] = lcg_next();
      write_mem(0, k, vec_a[k]);
   end
   set_port(CONF_MEM0A_IDX, 63, -1, 64, 0, 1'b0, 0);
   set_port(CONF_MEM0B_IDX, 0, 0, 0, 0, 1'b0, 0);
   set_port(CONF_MEM1A_IDX, 0, 0, 0, 0, 1'b0, 0);
   set_port(CONF_MEM1B_IDX, 0, 1, 64, 2, 1'b1, SRC_ALU0);
   set_alu(CONF_ALU0_IDX, PASSA, SRC_MEM0A, SRC_MEM0A);
   set_alu(CONF_ALU1_IDX, PASSA, SRC_MEM0A, SRC_MEM0A);
   start_run();
   wait_done("reverse_copy");
   for (int k = 0; k < MEM_DEPTH; k++) begin
      read_mem(1, k, got);
      check_word($sformatf("reverse_copy word %0d", k), vec_a[MEM_DEPTH-1-k], got);
   end
   finish_test("reverse_copy", err0);
endtask

task automatic shadow_config();
   int                err0;
   logic [DATA_W-1:0] got;
   err0 = errors;
   load_operands(16);
   set_binary_op(ADD);
   start_run();
   read_status(got);
   check_word("shadow_config status after strobe", 32'd0, got);
   // new config lands in the registers only and never in the running shadow
   set_alu(CONF_ALU0_IDX, XOR, SRC_MEM0B, SRC_MEM0A);
   set_port(CONF_MEM1B_IDX, 16, 1, 16, 0, 1'b1, SRC_MEM0A);
   wait_done("shadow_config");
   read_status(got);
   check_word("shadow_config status at end", 32'd1, got);
   check_binary_op("shadow_config", ADD);
   finish_test("shadow_config", err0);
endtask

// (a + b) - c with c read from mem1 16..31 one cycle after a and b
task automatic chained_pipeline();
   int                err0;
   logic [DATA_W-1:0] got;
   err0 = errors;
   load_operands(16);
   for (int k = 0; k < 16; k++) begin
      vec_c[k] = lcg_next();
      write_mem(1, 16 + k, vec_c[k]);
   end
   set_port(CONF_MEM0A_IDX, 0, 1, 16, 0, 1'b0, 0);
   set_port(CONF_MEM0B_IDX, 32, 1, 16, 0, 1'b0, 0);
   set_port(CONF_MEM1A_IDX, 16, 1, 16, 1, 1'b0, 0);
   set_port(CONF_MEM1B_IDX, 32, 1, 16, 3, 1'b1, SRC_ALU1);
   set_alu(CONF_ALU0_IDX, ADD, SRC_MEM0A, SRC_MEM0B);
   set_alu(CONF_ALU1_IDX, SUB, SRC_ALU0, SRC_MEM1A);
   start_run();
   wait_done("chained_pipeline");
   for (int k = 0; k < 16; k++) begin
      read_mem(1, 32 + k, got);
      check_word($sformatf("chained_pipeline word %0d", k),
                 vec_a[k] + vec_b[k] - vec_c[k], got);
   end
   finish_test("chained_pipeline", err0);
endtask

/* tests/tb_xversat.sv */
`timescale 1ns/1ps

module tb_xversat
   import xdata_pkg::*;
();

   localparam int          CLK_PERIOD   = 40;
   localparam int          RESET_CYCLES = 5;
   localparam int          POLL_LIMIT   = 200;
   localparam logic [31:0] LCG_SEED     = 32'h5518bc87;

   // rough length of each test in clock cycles
   localparam int MEM_CYCLES     = 400;
   localparam int ADD_CYCLES     = 100;
   localparam int OPS_CYCLES     = 520;
   localparam int REVERSE_CYCLES = 280;
   localparam int SHADOW_CYCLES  = 110;
   localparam int CHAIN_CYCLES   = 120;
   localparam int TEST_CYCLES    = RESET_CYCLES + MEM_CYCLES + ADD_CYCLES + OPS_CYCLES
                                   + REVERSE_CYCLES + SHADOW_CYCLES + CHAIN_CYCLES;

   // rst is the clock and clk the reset on this DUT
   logic                   rst;
   logic                   clk;
   logic                   valid;
   logic                   we;
   logic [HOST_ADDR_W-1:0] addr;
   logic [DATA_W-1:0]      rdata;
   logic [DATA_W-1:0]      wdata;

   logic [31:0]       lcg_state;
   int                errors;
   int                tests_run;
   int                tests_failed;
   logic [DATA_W-1:0] vec_a [MEM_DEPTH];
   logic [DATA_W-1:0] vec_b [MEM_DEPTH];
   logic [DATA_W-1:0] vec_c [MEM_DEPTH];

   xversat_top dut_i (
      .rst   (rst),
      .clk   (clk),
      .valid (valid),
      .we    (we),
      .addr  (addr),
      .rdata (rdata),
      .wdata (wdata)
   );

   `include "tb_xversat_tasks.svh"

   initial begin
      rst = 1'b0;
      forever #(CLK_PERIOD / 2) rst = ~rst;
   end

   // watchdog, twice the expected run length
   initial begin
      #(2 * TEST_CYCLES * CLK_PERIOD);
      $display("watchdog expired, the tests did not complete in time");
      $display("Result: FAILED");
      $finish;
   end

   initial begin
      clk          = 1'b1;
      valid        = 1'b0;
      we           = 1'b0;
      addr         = '0;
      rdata        = '0;
      lcg_state    = LCG_SEED;
      errors       = 0;
      tests_run    = 0;
      tests_failed = 0;

      repeat (RESET_CYCLES) @(posedge rst);
      #2;
      clk = 1'b0;

      memory_readback();
      vector_add();
      alu_opcodes();
      reverse_copy();
      shadow_config();
      chained_pipeline();

      $display("tests run: %0d, tests failed: %0d, checks failed: %0d",
               tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

/* sources.f */
+incdir+tests
src/xdata_pkg.sv
src/xaddr_gen.sv
src/xmem_unit.sv
src/xalu_unit.sv
src/xconf_regs.sv
src/xdata_eng.sv
src/xversat_top.sv
tests/tb_xversat.sv

/* Bender.yml */
package:
  name: xversat

sources:
  - src/xdata_pkg.sv
  - src/xaddr_gen.sv
  - src/xmem_unit.sv
  - src/xalu_unit.sv
  - src/xconf_regs.sv
  - src/xdata_eng.sv
  - src/xversat_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_xversat.sv
